// ==== Bender.yml ====
package:
  name: link_buffer

sources:
  - include_dirs:
      - design
    files:
      - design/link_pkg.sv
      - design/simple_dualport_mem.sv
      - design/simple_sync_fifo.sv
      - design/credit_egress.sv
      - design/link_cfg_regs.sv
      - design/link_buffer_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - dv/tb_clock_gen.sv
      - dv/link_tb.sv

// ==== design/credit_egress.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "link_settings.svh"

// downstream side of the link buffer
// pops the fifo while credits last, registers the flit out,
// and hands one credit back upstream per popped flit
module credit_egress (
  input  logic                          clk,
  input  logic                          reset,
  input  link_pkg::link_cfg_t           cfg,        // from register block
  // fifo head
  input  logic                          fifo_empty,
  input  link_pkg::flit_t               head,       // combinational head flit
  output logic                          pop,
  // downstream
  output logic                          out_valid,
  output link_pkg::flit_t               out_flit,
  input  logic                          out_credit, // one credit back per pulse
  // status and upstream
  output logic [`LINK_CREDIT_WIDTH-1:0] credits,    // live downstream credits
  output logic                          in_credit   // one slot freed upstream
);

  // ------------------------------------------------------------------------
  // send decision
  // ------------------------------------------------------------------------
  // every term must hold in the same cycle
  // held off while the counter reloads so no send goes uncounted
  assign pop = cfg.enable & ~cfg.credit_load & ~fifo_empty & (credits != '0);

  // ------------------------------------------------------------------------
  // downstream credit counter
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= '0;
    end else if (cfg.credit_load) begin
      credits <= cfg.credit_limit; // fresh start on enable
    end else begin
      unique case ({pop, out_credit})
        2'b10:   credits <= credits - 1'b1; // send only
        2'b01:   credits <= credits + 1'b1; // return only
        default: credits <= credits;        // idle or both cancel
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // output stage
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      in_credit <= 1'b0;
    end else begin
      out_valid <= pop;
      in_credit <= pop; // slot freed at the pop edge
    end
  end

  // flit register qualified by out_valid
  always_ff @(posedge clk) begin
    if (pop) begin
      out_flit <= head;
    end
  end

  // ------------------------------------------------------------------------
  // checks
  // ------------------------------------------------------------------------
  // a wrap below zero shows up as a huge count, so this covers both ends
  a_credit_in_range : assert property (@(posedge clk) disable iff (reset)
    credits <= cfg.credit_limit)
    else $error("downstream credits %0d above limit %0d",
                credits, cfg.credit_limit);

  // downstream returned a credit it never got
  a_no_extra_return : assert property (@(posedge clk) disable iff (reset)
    (out_credit && !pop && !cfg.credit_load) |-> credits < cfg.credit_limit)
    else $error("credit return with counter already at limit");

endmodule : credit_egress

`default_nettype wire

// ==== design/link_buffer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "link_settings.svh"

// single-lane credit link buffer
// upstream -> fifo -> credit egress -> downstream, regs on the side
module link_buffer_top (
  input  logic                            clk,
  input  logic                            reset,
  // upstream, credit based, no ready
  input  logic                            in_valid,
  input  link_pkg::flit_t                 in_flit,
  output logic                            in_credit,
  // downstream
  output logic                            out_valid,
  output link_pkg::flit_t                 out_flit,
  input  logic                            out_credit,
  // register port
  input  logic                            cfg_we,
  input  logic                            cfg_re,
  input  link_pkg::cfg_addr_e             cfg_addr,
  input  logic [`LINK_CFG_DATA_WIDTH-1:0] cfg_wdata,
  output logic [`LINK_CFG_DATA_WIDTH-1:0] cfg_rdata
);

  import link_pkg::*;

  flit_t                         fifo_head;  // head flit to egress
  logic                          fifo_empty;
  logic                          fifo_pop;
  link_cfg_t                     cfg;
  logic [`LINK_CREDIT_WIDTH-1:0] credits;    // egress count for readback

  // ------------------------------------------------------------------------
  // flit store, one spare slot keeps the depth a power of two
  // ------------------------------------------------------------------------
  simple_sync_fifo #(
    .payload_t (flit_t),
    .FIFO_DEPTH(`LINK_FIFO_DEPTH + 1)
  ) u_fifo (
    .clk       (clk),
    .reset     (reset),
    .push      (in_valid),
    .wr_data   (in_flit),
    .pop       (fifo_pop),
    .rd_data   (fifo_head),
    .fifo_full (),          // upstream credits keep it from filling past
    .fifo_empty(fifo_empty)
  );

  credit_egress u_egress (
    .clk       (clk),
    .reset     (reset),
    .cfg       (cfg),
    .fifo_empty(fifo_empty),
    .head      (fifo_head),
    .pop       (fifo_pop),
    .out_valid (out_valid),
    .out_flit  (out_flit),
    .out_credit(out_credit),
    .credits   (credits),
    .in_credit (in_credit)
  );

  link_cfg_regs u_regs (
    .clk      (clk),
    .reset    (reset),
    .cfg_we   (cfg_we),
    .cfg_re   (cfg_re),
    .cfg_addr (cfg_addr),
    .cfg_wdata(cfg_wdata),
    .cfg_rdata(cfg_rdata),
    .cfg      (cfg),
    .credits  (credits)
  );

endmodule : link_buffer_top

`default_nettype wire

// ==== design/link_cfg_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "link_settings.svh"

// control registers beside the egress
// plain strobe port, writes on the clock, reads combinational
module link_cfg_regs (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            cfg_we,    // write strobe
  input  logic                            cfg_re,    // read strobe
  input  link_pkg::cfg_addr_e             cfg_addr,
  input  logic [`LINK_CFG_DATA_WIDTH-1:0] cfg_wdata,
  output logic [`LINK_CFG_DATA_WIDTH-1:0] cfg_rdata,
  output link_pkg::link_cfg_t             cfg,       // to egress
  input  logic [`LINK_CREDIT_WIDTH-1:0]   credits    // live count from egress
);

  import link_pkg::*;

  logic                          enable_q;
  logic [`LINK_CREDIT_WIDTH-1:0] limit_q;
  logic                          load_q;    // credit_load pulse
  logic                          ctrl_wr;   // write to CFG_CTRL
  logic                          enable_up; // enable written 0 -> 1

  assign ctrl_wr   = cfg_we && (cfg_addr == CFG_CTRL);
  assign enable_up = ctrl_wr && cfg_wdata[0] && !enable_q;

  // ------------------------------------------------------------------------
  // registers
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      enable_q <= 1'b0;
      limit_q  <= '0;
      load_q   <= 1'b0;
    end else begin
      load_q <= enable_up; // one cycle, counter loads on the next edge
      if (ctrl_wr) enable_q <= cfg_wdata[0];
      if (cfg_we && (cfg_addr == CFG_LIMIT)) begin
        limit_q <= cfg_wdata[`LINK_CREDIT_WIDTH-1:0]; // upper bits dropped
      end
    end
  end

  assign cfg = '{enable: enable_q, credit_load: load_q, credit_limit: limit_q};

  // ------------------------------------------------------------------------
  // readback
  // ------------------------------------------------------------------------
  always_comb begin
    cfg_rdata = '0;
    if (cfg_re) begin
      unique case (cfg_addr)
        CFG_CTRL:    cfg_rdata[0] = enable_q;
        CFG_LIMIT:   cfg_rdata[`LINK_CREDIT_WIDTH-1:0] = limit_q;
        CFG_CREDITS: cfg_rdata[`LINK_CREDIT_WIDTH-1:0] = credits;
        default:     cfg_rdata = '0; // unmapped address
      endcase
    end
  end

endmodule : link_cfg_regs

`default_nettype wire

// ==== design/link_pkg.sv ====
`default_nettype none

`include "link_settings.svh"

package link_pkg;

  // ------------------------------------------------------------------------
  // link word
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic                        last; // final flit of a message
    logic [3:0]                  tag;  // message id
    logic [`LINK_DATA_WIDTH-1:0] data;
  } flit_t;

  // ------------------------------------------------------------------------
  // register block to egress
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic                          enable;       // forwarding on
    logic                          credit_load;  // one-cycle, reload counter
    logic [`LINK_CREDIT_WIDTH-1:0] credit_limit; // downstream buffer size
  } link_cfg_t;

  typedef enum logic [1:0] {
    CFG_CTRL    = 2'd0, // bit 0 enable
    CFG_LIMIT   = 2'd1, // credit limit
    CFG_CREDITS = 2'd2  // live credits, read only
  } cfg_addr_e;

endpackage : link_pkg

`default_nettype wire

// ==== design/link_settings.svh ====
`ifndef LINK_SETTINGS_SVH
`define LINK_SETTINGS_SVH

// flit payload width, tag and last ride on top
`define LINK_DATA_WIDTH 32

// usable fifo slots, also the upstream sender's starting credits
`define LINK_FIFO_DEPTH 15

// downstream credit counter, holds 0..16
`define LINK_CREDIT_WIDTH 5

`define LINK_CFG_DATA_WIDTH 16 // register port data width

`endif

// ==== design/simple_dualport_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

// storage under the fifo
// port a writes on the clock, port b reads straight from the array
module simple_dualport_mem #(
  parameter type payload_t = logic [31:0],  // stored word
  parameter int  DEPTH     = 16,            // number of entries
  localparam int ADDR_WIDTH = $clog2(DEPTH)
) (
  input  logic                  clk,
  // write port
  input  logic [ADDR_WIDTH-1:0] addra, // write address
  input  payload_t              dina,  // write data
  input  logic                  wea,   // write enable
  // read port
  input  logic [ADDR_WIDTH-1:0] addrb, // read address
  output payload_t              doutb  // read data, no latency
);

  payload_t mem [DEPTH]; // entry array

  // ------------------------------------------------------------------------
  // write side
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (wea) begin
      mem[addra] <= dina;
    end
  end

  // ------------------------------------------------------------------------
  // read side
  // ------------------------------------------------------------------------
  // head entry shows up in the same cycle
  always_comb begin
    doutb = mem[addrb];
  end

endmodule : simple_dualport_mem

`default_nettype wire

// ==== design/simple_sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

// pointer fifo, one slot kept open so full and empty differ
// usable depth is FIFO_DEPTH - 1
module simple_sync_fifo #(
  parameter type payload_t  = logic [31:0], // entry type
  parameter int  FIFO_DEPTH = 16,           // power of two for the wrap
  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH)
) (
  input  logic     clk,
  input  logic     reset,
  // write side
  input  logic     push,    // store wr_data
  input  payload_t wr_data,
  // read side
  input  logic     pop,     // drop head entry
  output payload_t rd_data, // head entry, combinational
  // flags
  output logic     fifo_full,
  output logic     fifo_empty
);

  logic [ADDR_WIDTH-1:0] wr_ptr;     // next slot to write
  logic [ADDR_WIDTH-1:0] rd_ptr;     // head slot
  logic [ADDR_WIDTH-1:0] wr_ptr_nxt;
  logic [ADDR_WIDTH-1:0] rd_ptr_nxt;
  logic                  do_push;    // accepted write
  logic                  do_pop;     // accepted read

  assign do_push = push & ~fifo_full;
  assign do_pop  = pop & ~fifo_empty;

  simple_dualport_mem #(
    .payload_t(payload_t),
    .DEPTH    (FIFO_DEPTH)
  ) u_mem (
    .clk  (clk),
    .addra(wr_ptr),
    .dina (wr_data),
    .wea  (do_push),
    .addrb(rd_ptr),
    .doutb(rd_data)
  );

  // ------------------------------------------------------------------------
  // pointers
  // ------------------------------------------------------------------------
  assign wr_ptr_nxt = wr_ptr + 1'b1; // wraps at FIFO_DEPTH
  assign rd_ptr_nxt = rd_ptr + 1'b1;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr_nxt;
      if (do_pop) rd_ptr <= rd_ptr_nxt; // head moves at the pop edge
    end
  end

  // flags
  assign fifo_full  = (wr_ptr_nxt == rd_ptr);
  assign fifo_empty = (wr_ptr == rd_ptr);

  // ------------------------------------------------------------------------
  // checks
  // ------------------------------------------------------------------------
  // upstream spent a credit it did not have
  a_no_overrun : assert property (@(posedge clk) disable iff (reset)
    push |-> !fifo_full)
    else $error("fifo push while full, upstream credit overrun");

  // egress must look at the empty flag before popping
  a_no_underrun : assert property (@(posedge clk) disable iff (reset)
    pop |-> !fifo_empty)
    else $error("fifo pop while empty");

endmodule : simple_sync_fifo

`default_nettype wire

// ==== dv/link_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "link_settings.svh"

// credit link buffer testbench
// sender and receiver models share one clocked process
// main process replays dv/link_tests.txt line by line
module link_tb;

  import link_pkg::*;

  // one parsed line of the test file
  typedef struct packed {
    logic [7:0]  kind; // w, r, f or c
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] v3;
    logic [31:0] v4;
  } test_line_t;

  logic                            clk;
  logic                            reset;
  logic                            in_valid   = 1'b0;
  flit_t                           in_flit    = '0;
  logic                            in_credit;
  logic                            out_valid;
  flit_t                           out_flit;
  logic                            out_credit = 1'b0;
  logic                            cfg_we;
  logic                            cfg_re;
  cfg_addr_e                       cfg_addr;
  logic [`LINK_CFG_DATA_WIDTH-1:0] cfg_wdata;
  logic [`LINK_CFG_DATA_WIDTH-1:0] cfg_rdata;

  test_line_t  lines  [$];
  flit_t       send_q [$];                        // upstream flits waiting for credits
  flit_t       sb_q   [$];                        // sent into the buffer oldest first
  int          up_credits = `LINK_FIFO_DEPTH;     // sender's own count
  int          owed, permits, gap;                // downstream return model
  int          idle_cycles, off_cycles, rst_edges;
  int          out_count, in_count, errors, checks, cycles;
  int          limit      = 1000000;              // replaced after the file is read
  logic        en_model   = 1'b0;                 // enable as last written
  logic [15:0] lim_model  = '0;

  tb_clock_gen clock_gen (.clk(clk));

  link_buffer_top UUT (.*);

  // --------------------------------------------------------------------------
  // link models sample at the edge and drive 1 ns later
  // --------------------------------------------------------------------------
  always @(posedge clk) begin : link_models
    flit_t exp_flit;
    flit_t tx_flit;
    logic  send;
    logic  ret;
    tx_flit = '0;
    if (rst_edges == 0) begin
      gap = $urandom(32'h9cd50bbc) % 4; // seed this process's stream once
    end
    if (reset) begin
      if (rst_edges > 0 && (out_valid !== 1'b0 || in_credit !== 1'b0)) begin
        errors++;
        $display("error %0t: out_valid or in_credit high during reset", $time);
      end
      rst_edges++;
    end else begin
      if (out_valid) begin
        out_count++;
        owed++; // receiver now holds it
        checks++;
        if (sb_q.size() == 0) begin
          errors++;
          $display("error %0t: flit %h delivered but none outstanding", $time, out_flit);
        end else begin
          exp_flit = sb_q.pop_front();
          if (out_flit !== exp_flit) begin
            errors++;
            $display("error %0t: got last %0b tag %h data %h, expected last %0b tag %h data %h",
                     $time, out_flit.last, out_flit.tag, out_flit.data,
                     exp_flit.last, exp_flit.tag, exp_flit.data);
          end
        end
      end
      if (in_credit) begin
        in_count++;
        up_credits++;
      end
      // nothing may leave once enable is low for two edges
      if (off_cycles >= 2 && (out_valid !== 1'b0 || in_credit !== 1'b0)) begin
        errors++;
        $display("error %0t: output activity while enable is off", $time);
      end
      // credits held plus flits in flight always make the full depth
      if (up_credits < 0 || up_credits + sb_q.size() != `LINK_FIFO_DEPTH) begin
        errors++;
        $display("error %0t: upstream credits %0d with %0d in flight", $time,
                 up_credits, sb_q.size());
      end
      if (owed > lim_model) begin
        errors++;
        $display("error %0t: receiver holds %0d flits, limit %0d", $time, owed, lim_model);
      end
    end
    off_cycles = en_model ? 0 : off_cycles + 1;
    // sender spends one credit per flit and never goes below zero
    send = !reset && send_q.size() > 0 && up_credits > 0;
    if (send) begin
      tx_flit = send_q.pop_front();
      sb_q.push_back(tx_flit);
      up_credits--;
    end
    // receiver hands credits back with a random gap
    ret = !reset && gap == 0 && permits > 0 && owed > 0;
    if (ret) begin
      owed--;
      permits--;
      gap = $urandom % 4; // 0..3 cycles
    end else if (gap > 0) begin
      gap--;
    end
    if (out_valid || in_credit || out_credit || send || ret) idle_cycles = 0;
    else idle_cycles++;
    #1;
    in_valid   = send;
    in_flit    = tx_flit;
    out_credit = ret;
  end

  always @(posedge clk) begin : watchdog
    cycles++;
    if (cycles > limit) begin
      $display("timeout, run still busy after %0d cycles", limit);
      $display("Some tests failed");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // helpers are entered and left 1 ns after an edge
  // --------------------------------------------------------------------------
  // idle link or sender stalled on zero credits
  task automatic wait_quiet();
    idle_cycles = 0; // count quiet edges from here on
    do begin
      @(posedge clk);
      #1;
    end while (!((send_q.size() == 0 || up_credits == 0) && idle_cycles >= 8));
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    cfg_we    = 1'b1;
    cfg_addr  = cfg_addr_e'(addr[1:0]);
    cfg_wdata = data[`LINK_CFG_DATA_WIDTH-1:0];
    if (addr == CFG_CTRL) en_model = data[0];
    if (addr == CFG_LIMIT) lim_model = data[15:0];
    @(posedge clk);
    #1;
    cfg_we = 1'b0;
  endtask

  task automatic check_reg(input logic [31:0] addr, input logic [31:0] exp_val,
                           input logic [31:0] exp_out);
    wait_quiet();
    cfg_re   = 1'b1;
    cfg_addr = cfg_addr_e'(addr[1:0]);
    #3; // read data settles by mid cycle
    checks += 2;
    if (cfg_rdata !== exp_val[15:0]) begin
      errors++;
      $display("error %0t: register %0d read %h, expected %h", $time, addr, cfg_rdata,
               exp_val[15:0]);
    end
    if (out_count != exp_out) begin
      errors++;
      $display("error %0t: %0d flits delivered, expected %0d", $time, out_count, exp_out);
    end
    @(posedge clk);
    #1;
    cfg_re = 1'b0;
  endtask

  // burst with counting data and last only on the final flit
  task automatic queue_flits(input logic [3:0] tag, input logic last, input logic [31:0] base,
                             input int count);
    flit_t f;
    for (int i = 0; i < count; i++) begin
      f.tag  = tag;
      f.data = base + i;
      f.last = last && (i == count - 1);
      send_q.push_back(f);
    end
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial begin : main
    int            fd;
    int            code;
    logic [7:0]    kind;
    logic [1023:0] skip;
    test_line_t    ln;
    reset     = 1'b1;
    cfg_we    = 1'b0;
    cfg_re    = 1'b0;
    cfg_addr  = CFG_CTRL;
    cfg_wdata = '0;
    fd        = $fopen("dv/link_tests.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open dv/link_tests.txt, no test lines were run");
    end
    while (fd != 0 && $fscanf(fd, "%s", kind) == 1) begin
      ln      = '0;
      ln.kind = kind;
      case (kind)
        "#":     code = ($fgets(skip, fd) > 0) ? 0 : -1; // column notes
        "w":     code = $fscanf(fd, "%h %h", ln.v1, ln.v2) - 2;
        "r":     code = $fscanf(fd, "%h %h %d", ln.v1, ln.v2, ln.v3) - 3;
        "f":     code = $fscanf(fd, "%h %d %h %d", ln.v1, ln.v2, ln.v3, ln.v4) - 4;
        "c":     code = $fscanf(fd, "%d", ln.v1) - 1;
        default: code = -1;
      endcase
      if (code != 0) begin
        errors++;
        $display("test file entry %0d could not be read, rest of file skipped",
                 lines.size() + 1);
        break;
      end
      if (kind != "#") lines.push_back(ln);
    end
    if (fd != 0) $fclose(fd);
    limit = 40 * lines.size() + 200;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    foreach (lines[i]) begin
      case (lines[i].kind)
        "w":     write_reg(lines[i].v1, lines[i].v2);
        "r":     check_reg(lines[i].v1, lines[i].v2, lines[i].v3);
        "f":     queue_flits(lines[i].v1[3:0], lines[i].v2[0], lines[i].v3, lines[i].v4);
        "c":     permits += lines[i].v1;
        default: ;
      endcase
    end
    wait_quiet();
    checks += 2;
    if (send_q.size() != 0 || sb_q.size() != 0) begin
      errors++;
      $display("error %0t: %0d flits never sent, %0d never delivered", $time,
               send_q.size(), sb_q.size());
    end
    if (in_count != out_count) begin
      errors++;
      $display("error %0t: %0d upstream credits for %0d flits out", $time, in_count,
               out_count);
    end
    $display("summary: %0d checks, %0d errors, %0d flits out, %0d upstream credits",
             checks, errors, out_count, in_count);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule : link_tb

`default_nettype wire

// ==== dv/link_tests.txt ====
# w addr data | r addr expect flits_out | f tag last data count | c returns
# addr, data, expect and tag in hex; last, flits_out, count and returns in decimal
r 2 0000 0
r 0 0000 0
w 1 0004
r 1 0004 0
w 0 0001
f 1 1 a0000000 8
r 2 0000 4
c 8
r 2 0004 8
w 0 0000
w 1 0008
w 0 0001
c 10
f 2 0 b0000000 6
f 3 1 b1000000 4
r 2 0008 18
w 0 0000
f 5 1 c0000000 16
r 2 0008 18
r 0 0000 18
w 0 0001
c 16
r 2 0008 34
r 1 0008 34

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

// free-running testbench clock, starts low
module tb_clock_gen #(
  parameter real PERIOD_NS = 8.0 // full period
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk; // half period per toggle
  end

endmodule : tb_clock_gen

`default_nettype wire

// ==== sim.f ====
+incdir+design
design/link_pkg.sv
design/simple_dualport_mem.sv
design/simple_sync_fifo.sv
design/credit_egress.sv
design/link_cfg_regs.sv
design/link_buffer_top.sv
dv/tb_clock_gen.sv
dv/link_tb.sv
